// ==== Bender.yml ====
package:
  name: hc_converter

sources:
  - files:
      - hdl/hc_ctrl_pkg.sv
      - hdl/hc_bridge_pkg.sv
      - hdl/tank_sample_if.sv
      - hdl/tank_adc_capture.sv
      - hdl/phi_setpoint.sv
      - hdl/hybrid_switching_law.sv
      - hdl/dead_time.sv
      - hdl/bridge_sequencer.sv
      - hdl/hc_converter_top.sv
  - target: test
    files:
      - bench/hc_converter_sva.sv
      - bench/hc_converter_tb.sv

// ==== bench/hc_converter_sva.sv ====
// Gate output assertions
`default_nettype none
`timescale 1ns/1ps

module hc_converter_sva (
   input logic                              i_clk,
   input logic                              i_rst_n,
   input logic                              i_enable,
   input logic [hc_bridge_pkg::GATE_W-1:0]  i_q,
   input logic                              i_on
);

   // leg 1 is Q1/Q3, leg 2 is Q2/Q4
   a_no_shoot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !((i_q[0] && i_q[2]) || (i_q[1] && i_q[3])))
      else $error("shoot-through pattern %b on o_q", i_q);

   // bridge off one cycle after enable is low
   a_off_disabled: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !i_enable |=> (i_q == '0 && !i_on))
      else $error("o_q %b or o_on set while disabled", i_q);

   // rising gate needs all off before it
   // start-up phase changes are exempt
   a_rise_after_off: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (|(i_q & ~$past(i_q))) |-> ($past(i_q) == '0 || !$past(i_on)))
      else $error("gate rose from %b without dead time", $past(i_q));

endmodule

bind hc_converter_top hc_converter_sva hc_converter_sva_i (
   .i_clk    (ADA_DCO),
   .i_rst_n  (i_rst_n),
   .i_enable (i_enable),
   .i_q      (o_q),
   .i_on     (o_on)
);

`default_nettype wire

// ==== bench/hc_converter_tb.sv ====
// Converter control testbench
`default_nettype none
`timescale 1ns/1ps

module hc_converter_tb;

   import hc_ctrl_pkg::*;
   import hc_bridge_pkg::*;

   localparam int TIMEOUT = 60;
   // cycles each random sample is held
   localparam int HOLD    = 40;

   logic                    ADA_DCO;
   logic                    rst_n;
   logic signed [ADC_W-1:0] ada_data;
   logic signed [ADC_W-1:0] adb_data;
   logic                    ada_or;
   logic                    adb_or;
   logic                    enable;
   logic                    inc_btn;
   logic                    dec_btn;
   logic [1:0]              dt_sel;
   logic [GATE_W-1:0]       q;
   logic                    bridge_on;
   logic [PHI_W-1:0]        phi;

   integer                  seed = 14252;
   int                      errors = 0;
   int                      test_count = 0;
   int                      failed_tests = 0;
   // setpoint as the tb expects it
   logic [PHI_W-1:0]        exp_phi;
   // compare process control
   logic                    law_check;
   logic [GATE_W-1:0]       law_exp;

   hc_converter_top hc_converter_top_i (
      .ADA_DCO    (ADA_DCO),
      .i_rst_n    (rst_n),
      .i_ada_data (ada_data),
      .i_adb_data (adb_data),
      .i_ada_or   (ada_or),
      .i_adb_or   (adb_or),
      .i_enable   (enable),
      .i_inc_btn  (inc_btn),
      .i_dec_btn  (dec_btn),
      .i_dt_sel   (dt_sel),
      .o_q        (q),
      .o_on       (bridge_on),
      .o_phi      (phi)
   );

   // 40 ns period
   initial begin
      ADA_DCO = 1'b0;
      forever #20 ADA_DCO = ~ADA_DCO;
   end

   // ====================
   // reference model
   // ====================

   // surface on the raw words, both channels arrive inverted
   function automatic sigma_t ref_sigma(input logic signed [ADC_W-1:0] raw_a,
                                        input logic signed [ADC_W-1:0] raw_b,
                                        input logic [PHI_W-1:0]        phi_set);
      logic signed [ADC_W-1:0] vc;
      logic signed [ADC_W-1:0] ic;
      int                      surf;
      vc   = -raw_a;
      ic   = -raw_b;
      // gain of 32 on vC
      surf = int'(vc) * (1 << VC_SHIFT) - int'(ic) * int'(phi_set);
      return (surf >= 0) ? SIGMA_POS : SIGMA_NEG;
   endfunction

   function automatic logic [GATE_W-1:0] gates_for(input sigma_t s);
      return (s == SIGMA_POS) ? GATES_POS : GATES_NEG;
   endfunction

   // ====================
   // compare tasks
   // ====================

   task automatic check_gates(input logic [GATE_W-1:0] exp, input string what);
      if (q !== exp) begin
         $display("** Error at %0t ns: %s, o_q %b expected %b", $time, what, q, exp);
         errors++;
      end
   endtask

   task automatic check_phi(input logic [PHI_W-1:0] exp, input string what);
      if (phi !== exp) begin
         $display("** Error at %0t ns: %s, o_phi %0d expected %0d", $time, what, phi, exp);
         errors++;
      end
   endtask

   task automatic check_on(input logic exp, input string what);
      if (bridge_on !== exp) begin
         $display("** Error at %0t ns: %s, o_on %b expected %b", $time, what, bridge_on, exp);
         errors++;
      end
   endtask

   task automatic check_count(input int got, input int lo, input int hi, input string what);
      if (got < lo || got > hi) begin
         $display("** Error at %0t ns: %s, %0d cycles expected %0d to %0d",
                  $time, what, got, lo, hi);
         errors++;
      end
   endtask

   // held run patterns, checked on every falling edge
   always @(negedge ADA_DCO) begin
      if (law_check) begin
         check_gates(law_exp, "held sample");
      end
   end

   // ====================
   // stimulus and waits
   // ====================

   task automatic drive_sample(input logic signed [ADC_W-1:0] a,
                               input logic signed [ADC_W-1:0] b,
                               input logic                    flag);
      @(posedge ADA_DCO);
      ada_data <= a;
      adb_data <= b;
      ada_or   <= flag;
   endtask

   // one button pulse, then the tb copy of phi steps as well
   task automatic press(input logic inc, input logic dec);
      @(posedge ADA_DCO);
      inc_btn <= inc;
      dec_btn <= dec;
      @(posedge ADA_DCO);
      inc_btn <= 1'b0;
      dec_btn <= 1'b0;
      // o_phi moves two cycles after the level
      repeat (2) @(posedge ADA_DCO);
      @(negedge ADA_DCO);
      if (inc && !dec) begin
         exp_phi = (exp_phi > PHI_MAX - PHI_STEP) ? PHI_W'(PHI_MAX) : exp_phi + PHI_STEP;
      end else if (dec && !inc) begin
         exp_phi = (exp_phi < PHI_MIN + PHI_STEP) ? PHI_W'(PHI_MIN) : exp_phi - PHI_STEP;
      end
      check_phi(exp_phi, "setpoint after button");
   endtask

   task automatic wait_gates(input logic [GATE_W-1:0] exp, input int limit, output int waited);
      waited = 0;
      @(negedge ADA_DCO);
      while (q !== exp && waited < limit) begin
         waited++;
         @(negedge ADA_DCO);
      end
      if (q !== exp) begin
         $display("timeout: o_q never reached %b within %0d cycles", exp, limit);
         errors++;
      end
   endtask

   // called on a falling edge, stops at the first other value
   task automatic count_hold(input logic [GATE_W-1:0] val, input int limit, output int n);
      n = 0;
      while (q === val && n < limit) begin
         n++;
         @(negedge ADA_DCO);
      end
      if (q === val) begin
         $display("timeout: o_q stuck at %b for %0d cycles", val, limit);
         errors++;
      end
   endtask

   task automatic end_test(input string name, input int errs_before);
      test_count++;
      if (errors == errs_before) begin
         $display("test %0d %s: ok", test_count, name);
      end else begin
         failed_tests++;
         $display("test %0d %s: failed with %0d errors", test_count, name,
                  errors - errs_before);
      end
   endtask

   // ====================
   // test sequence
   // ====================

   initial begin
      logic [GATE_W-1:0]       p_now;
      logic [GATE_W-1:0]       p_next;
      logic signed [ADC_W-1:0] ra;
      logic signed [ADC_W-1:0] rb;
      int                      n;
      int                      waited;
      int                      mark;
      rst_n     = 1'b0;
      ada_data  = '0;
      adb_data  = '0;
      ada_or    = 1'b0;
      adb_or    = 1'b0;
      enable    = 1'b0;
      inc_btn   = 1'b0;
      dec_btn   = 1'b0;
      dt_sel    = 2'd0;
      exp_phi   = PHI_W'(PHI_MIN);
      law_check = 1'b0;
      law_exp   = '0;
      repeat (3) @(posedge ADA_DCO);
      rst_n <= 1'b1;
      @(negedge ADA_DCO);

      // setpoint steps, clamps at both ends, ends at 30
      mark = errors;
      check_gates('0, "after reset");
      check_phi(exp_phi, "after reset");
      repeat (20) press(1'b1, 1'b0);
      repeat (22) press(1'b0, 1'b1);
      repeat (6) press(1'b1, 1'b0);
      press(1'b1, 1'b1);
      end_test("setpoint", mark);

      // start-up, negative sigma so run differs from precharge
      mark = errors;
      ra = 14'sd100;
      rb = 14'sd0;
      p_next = gates_for(ref_sigma(ra, rb, exp_phi));
      drive_sample(ra, rb, 1'b0);
      // pipeline plus shortest dead time
      repeat (10) @(posedge ADA_DCO);
      enable <= 1'b1;
      @(negedge ADA_DCO);
      count_hold('0, TIMEOUT, n);
      check_gates(GATES_BOOT, "boot phase");
      check_on(1'b0, "boot phase");
      count_hold(GATES_BOOT, TIMEOUT, n);
      check_count(n, BOOT_CYCLES, BOOT_CYCLES, "boot length");
      check_gates(GATES_POS, "precharge phase");
      check_on(1'b0, "precharge phase");
      count_hold(GATES_POS, TIMEOUT, n);
      check_count(n, PRECHARGE_CYCLES, PRECHARGE_CYCLES, "precharge length");
      check_gates(p_next, "first run pattern");
      check_on(1'b1, "first run cycle");
      end_test("start-up", mark);

      // random held samples against the surface rule
      mark = errors;
      for (int k = 0; k < 30; k++) begin
         ra = ADC_W'($random(seed));
         rb = ADC_W'($random(seed));
         p_next = gates_for(ref_sigma(ra, rb, exp_phi));
         drive_sample(ra, rb, 1'b0);
         wait_gates(p_next, HOLD / 2, waited);
         law_exp   = p_next;
         law_check = 1'b1;
         repeat (HOLD - waited - 1) @(negedge ADA_DCO);
         law_check = 1'b0;
      end
      end_test("switching law", mark);

      // reversal under each dead-time setting
      mark = errors;
      for (int sel = 0; sel < 4; sel++) begin
         @(posedge ADA_DCO);
         dt_sel <= 2'(sel);
         @(negedge ADA_DCO);
         p_now = q;
         ra = (p_now === GATES_POS) ? 14'sd100 : -14'sd100;
         p_next = gates_for(ref_sigma(ra, 14'sd0, exp_phi));
         drive_sample(ra, 14'sd0, 1'b0);
         @(negedge ADA_DCO);
         // old pair stays until the new sigma arrives
         count_hold(p_now, TIMEOUT, n);
         check_gates('0, "start of dead time");
         count_hold('0, TIMEOUT, n);
         check_count(n, int'(DT_CYCLES[sel]), TIMEOUT, "dead time");
         check_gates(p_next, "after dead time");
      end
      end_test("dead time", mark);

      // flagged sample must not move sigma
      mark = errors;
      @(negedge ADA_DCO);
      p_now = q;
      ra = (p_now === GATES_POS) ? 14'sd100 : -14'sd100;
      p_next = gates_for(ref_sigma(ra, 14'sd0, exp_phi));
      drive_sample(ra, 14'sd0, 1'b1);
      repeat (20) begin
         @(negedge ADA_DCO);
         check_gates(p_now, "over-range sample");
      end
      drive_sample(ra, 14'sd0, 1'b0);
      wait_gates(p_next, TIMEOUT, waited);
      end_test("over range", mark);

      // disable while running, bridge off within two cycles
      mark = errors;
      check_on(1'b1, "before disable");
      @(posedge ADA_DCO);
      enable <= 1'b0;
      n = 0;
      @(negedge ADA_DCO);
      while ((q !== '0 || bridge_on !== 1'b0) && n < 2) begin
         n++;
         @(negedge ADA_DCO);
      end
      if (q !== '0 || bridge_on !== 1'b0) begin
         $display("timeout: bridge still on %0d cycles after disable", n);
      end
      check_gates('0, "after disable");
      check_on(1'b0, "after disable");
      end_test("disable", mark);

      $display("tests run %0d, failed %0d, errors %0d", test_count, failed_tests, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/hc_ctrl_pkg.sv
hdl/hc_bridge_pkg.sv
hdl/tank_sample_if.sv
hdl/tank_adc_capture.sv
hdl/phi_setpoint.sv
hdl/hybrid_switching_law.sv
hdl/dead_time.sv
hdl/bridge_sequencer.sv
hdl/hc_converter_top.sv
bench/hc_converter_sva.sv
bench/hc_converter_tb.sv

// ==== hdl/bridge_sequencer.sv ====
// H-bridge start-up sequencer
`default_nettype none
`timescale 1ns/1ps

module bridge_sequencer (
   input  logic                              i_clk_dco,
   input  logic                              i_rst_n,
   input  logic                              i_enable,
   input  logic [hc_bridge_pkg::GATE_W-1:0]  i_gates,
   output logic [hc_bridge_pkg::GATE_W-1:0]  o_q,
   output logic                              o_on
);

   import hc_bridge_pkg::*;

   bridge_state_t     state_q;
   logic [SEQ_W-1:0]  cnt_q;
   logic [GATE_W-1:0] pattern;
   logic              shoot;
   logic [GATE_W-1:0] q_q;
   logic              on_q;

   // ====================
   // phase FSM
   // ====================

   // enable low always drops back to idle
   always_ff @(posedge i_clk_dco) begin
      if (!i_rst_n || !i_enable) begin
         state_q <= BR_IDLE;
         cnt_q   <= '0;
      end else begin
         case (state_q)
            BR_IDLE: begin
               state_q <= BR_BOOT;
               cnt_q   <= '0;
            end
            BR_BOOT: begin
               // low sides on, charge bootstrap caps
               if (cnt_q == SEQ_W'(BOOT_CYCLES - 1)) begin
                  state_q <= BR_PRECHARGE;
                  cnt_q   <= '0;
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            BR_PRECHARGE: begin
               // sigma forced positive to excite the tank
               if (cnt_q == SEQ_W'(PRECHARGE_CYCLES - 1)) begin
                  state_q <= BR_RUN;
                  cnt_q   <= '0;
               end else begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            default: begin
               state_q <= BR_RUN;
            end
         endcase
      end
   end

   // pattern for the current phase
   always_comb begin
      case (state_q)
         BR_BOOT:      pattern = GATES_BOOT;
         BR_PRECHARGE: pattern = GATES_POS;
         BR_RUN:       pattern = i_gates;
         default:      pattern = '0;
      endcase
   end

   // leg 1 is Q1/Q3, leg 2 is Q2/Q4
   assign shoot = (pattern[0] & pattern[2]) | (pattern[1] & pattern[3]);

   // ====================
   // registered outputs
   // ====================

   always_ff @(posedge i_clk_dco) begin
      if (!i_rst_n) begin
         q_q  <= '0;
         on_q <= 1'b0;
      end else begin
         q_q  <= (!i_enable || shoot) ? '0 : pattern;
         on_q <= i_enable && (state_q == BR_RUN);
      end
   end

   assign o_q  = q_q;
   assign o_on = on_q;

endmodule

`default_nettype wire

// ==== hdl/dead_time.sv ====
// Gate dead-time insertion
`default_nettype none
`timescale 1ns/1ps

module dead_time (
   input  logic                              i_clk_dco,
   input  logic                              i_rst_n,
   input  hc_ctrl_pkg::sigma_t               i_sigma,
   input  logic [1:0]                        i_dt_sel,
   output logic [hc_bridge_pkg::GATE_W-1:0]  o_gates
);

   import hc_ctrl_pkg::*;
   import hc_bridge_pkg::*;

   logic [GATE_W-1:0] req;
   logic [GATE_W-1:0] gates_q;
   logic [DT_W-1:0]   dt_len;
   // one on-delay counter per switch
   logic [DT_W-1:0]   cnt_q [GATE_W];

   // sigma to the diagonal pair
   assign req    = (i_sigma == SIGMA_POS) ? GATES_POS : GATES_NEG;
   assign dt_len = DT_CYCLES[i_dt_sel];

   // turn-off is immediate, turn-on waits dt_len cycles of steady request
   // so the old pair is off for the full dead time before the new pair
   always_ff @(posedge i_clk_dco) begin
      if (!i_rst_n) begin
         gates_q <= '0;
         for (int g = 0; g < GATE_W; g++) begin
            cnt_q[g] <= '0;
         end
      end else begin
         for (int g = 0; g < GATE_W; g++) begin
            if (!req[g]) begin
               cnt_q[g]   <= '0;
               gates_q[g] <= 1'b0;
            end else if (cnt_q[g] >= dt_len) begin
               gates_q[g] <= 1'b1;
            end else begin
               cnt_q[g] <= cnt_q[g] + 1'b1;
            end
         end
      end
   end

   assign o_gates = gates_q;

endmodule

`default_nettype wire

// ==== hdl/hc_bridge_pkg.sv ====
// H-bridge side definitions
`default_nettype none

package hc_bridge_pkg;

   // gate bits: 0 Q1 hi leg1, 1 Q2 hi leg2, 2 Q3 lo leg1, 3 Q4 lo leg2
   localparam int GATE_W = 4;

   // Q1 + Q4, positive tank voltage
   localparam logic [GATE_W-1:0] GATES_POS  = 4'b1001;
   // Q2 + Q3, negative tank voltage
   localparam logic [GATE_W-1:0] GATES_NEG  = 4'b0110;
   // both low sides, bootstrap charge
   localparam logic [GATE_W-1:0] GATES_BOOT = 4'b1100;

   // ====================
   // dead time
   // ====================

   localparam int DT_W = 4;
   // indexed by the 2-bit select
   localparam logic [3:0][DT_W-1:0] DT_CYCLES = {DT_W'(8), DT_W'(6), DT_W'(4), DT_W'(2)};

   // ====================
   // start-up sequence
   // ====================

   localparam int SEQ_W            = 4;
   localparam int BOOT_CYCLES      = 10;
   localparam int PRECHARGE_CYCLES = 6;

   typedef enum logic [1:0] {
      BR_IDLE      = 2'd0,
      BR_BOOT      = 2'd1,
      BR_PRECHARGE = 2'd2,
      BR_RUN       = 2'd3
   } bridge_state_t;

endpackage

`default_nettype wire

// ==== hdl/hc_converter_top.sv ====
// Resonant converter control top
`default_nettype none
`timescale 1ns/1ps

module hc_converter_top (
   input  logic                                   ADA_DCO,
   input  logic                                   i_rst_n,
   input  logic signed [hc_ctrl_pkg::ADC_W-1:0]  i_ada_data,
   input  logic signed [hc_ctrl_pkg::ADC_W-1:0]  i_adb_data,
   input  logic                                   i_ada_or,
   input  logic                                   i_adb_or,
   input  logic                                   i_enable,
   input  logic                                   i_inc_btn,
   input  logic                                   i_dec_btn,
   input  logic [1:0]                             i_dt_sel,
   output logic [hc_bridge_pkg::GATE_W-1:0]       o_q,
   output logic                                   o_on,
   output logic [hc_ctrl_pkg::PHI_W-1:0]          o_phi
);

   import hc_ctrl_pkg::*;
   import hc_bridge_pkg::*;

   tank_sample_if     smp_if ();
   logic [PHI_W-1:0]  phi;
   sigma_t            sigma;
   // after dead time, before start-up gating
   logic [GATE_W-1:0] gates_dt;

   tank_adc_capture tank_adc_capture_i (
      .i_clk_dco  (ADA_DCO),
      .i_rst_n    (i_rst_n),
      .i_ada_data (i_ada_data),
      .i_adb_data (i_adb_data),
      .i_ada_or   (i_ada_or),
      .i_adb_or   (i_adb_or),
      .o_smp      (smp_if)
   );

   phi_setpoint phi_setpoint_i (
      .i_clk_dco (ADA_DCO),
      .i_rst_n   (i_rst_n),
      .i_inc_btn (i_inc_btn),
      .i_dec_btn (i_dec_btn),
      .o_phi     (phi)
   );

   hybrid_switching_law hybrid_switching_law_i (
      .i_clk_dco (ADA_DCO),
      .i_rst_n   (i_rst_n),
      .i_smp     (smp_if),
      .i_phi     (phi),
      .o_sigma   (sigma)
   );

   dead_time dead_time_i (
      .i_clk_dco (ADA_DCO),
      .i_rst_n   (i_rst_n),
      .i_sigma   (sigma),
      .i_dt_sel  (i_dt_sel),
      .o_gates   (gates_dt)
   );

   bridge_sequencer bridge_sequencer_i (
      .i_clk_dco (ADA_DCO),
      .i_rst_n   (i_rst_n),
      .i_enable  (i_enable),
      .i_gates   (gates_dt),
      .o_q       (o_q),
      .o_on      (o_on)
   );

   assign o_phi = phi;

endmodule

`default_nettype wire

// ==== hdl/hc_ctrl_pkg.sv ====
// Control side definitions
`default_nettype none

package hc_ctrl_pkg;

   // ====================
   // tank adc
   // ====================

   // raw word width of both tank channels
   localparam int ADC_W = 14;

   // ====================
   // phi setpoint
   // ====================

   localparam int PHI_W    = 8;
   localparam int PHI_STEP = 5;
   localparam int PHI_MIN  = 0;
   localparam int PHI_MAX  = 90;

   // ====================
   // switching surface
   // ====================

   // vC gain of 32 before the compare
   localparam int VC_SHIFT = 5;
   // holds (vC << 5) - iC * phi without overflow
   localparam int SURF_W   = 23;

   // switching variable
   typedef enum logic {
      SIGMA_NEG = 1'b0,
      SIGMA_POS = 1'b1
   } sigma_t;

endpackage

`default_nettype wire

// ==== hdl/hybrid_switching_law.sv ====
// Hybrid switching law
`default_nettype none
`timescale 1ns/1ps

module hybrid_switching_law (
   input  logic                            i_clk_dco,
   input  logic                            i_rst_n,
   tank_sample_if.dst                      i_smp,
   input  logic [hc_ctrl_pkg::PHI_W-1:0]   i_phi,
   output hc_ctrl_pkg::sigma_t             o_sigma
);

   import hc_ctrl_pkg::*;

   // operands widened to the surface width
   logic signed [SURF_W-1:0] vc_ext;
   logic signed [SURF_W-1:0] ic_ext;
   logic signed [SURF_W-1:0] phi_ext;
   logic signed [SURF_W-1:0] surf_d;
   // stage 1
   logic signed [SURF_W-1:0] surf_q;
   logic                     valid_q;
   logic                     or_q;
   // stage 2
   sigma_t                   sigma_q;

   // ====================
   // stage 1, surface
   // ====================

   always_comb begin
      vc_ext  = {{(SURF_W-ADC_W){i_smp.vc[ADC_W-1]}}, i_smp.vc};
      ic_ext  = {{(SURF_W-ADC_W){i_smp.ic[ADC_W-1]}}, i_smp.ic};
      // phi is an angle, never negative
      phi_ext = {{(SURF_W-PHI_W){1'b0}}, i_phi};
      // s = 32*vC - phi*iC
      surf_d  = (vc_ext <<< VC_SHIFT) - ic_ext * phi_ext;
   end

   always_ff @(posedge i_clk_dco) begin
      surf_q <= surf_d;
   end

   // flags travel alongside the product
   always_ff @(posedge i_clk_dco) begin
      if (!i_rst_n) begin
         valid_q <= 1'b0;
         or_q    <= 1'b0;
      end else begin
         valid_q <= i_smp.valid;
         or_q    <= i_smp.over_range;
      end
   end

   // ====================
   // stage 2, sigma
   // ====================

   // zero counts as positive, clipped samples hold sigma
   always_ff @(posedge i_clk_dco) begin
      if (!i_rst_n) begin
         sigma_q <= SIGMA_NEG;
      end else if (valid_q && !or_q) begin
         sigma_q <= surf_q[SURF_W-1] ? SIGMA_NEG : SIGMA_POS;
      end
   end

   assign o_sigma = sigma_q;

endmodule

`default_nettype wire

// ==== hdl/phi_setpoint.sv ====
// Phi setpoint register
`default_nettype none
`timescale 1ns/1ps

module phi_setpoint (
   input  logic                            i_clk_dco,
   input  logic                            i_rst_n,
   input  logic                            i_inc_btn,
   input  logic                            i_dec_btn,
   output logic [hc_ctrl_pkg::PHI_W-1:0]   o_phi
);

   import hc_ctrl_pkg::*;

   // bit 0 increase, bit 1 decrease
   logic [1:0]       btn_q;
   logic [1:0]       btn_qq;
   logic             inc_rise;
   logic             dec_rise;
   logic [PHI_W-1:0] phi_q;

   // sample levels, then keep the previous one
   always_ff @(posedge i_clk_dco) begin
      if (!i_rst_n) begin
         btn_q  <= 2'b00;
         btn_qq <= 2'b00;
      end else begin
         btn_q  <= {i_dec_btn, i_inc_btn};
         btn_qq <= btn_q;
      end
   end

   // rising edges only
   assign inc_rise = btn_q[0] & ~btn_qq[0];
   assign dec_rise = btn_q[1] & ~btn_qq[1];

   // step with saturation, both at once is ignored
   always_ff @(posedge i_clk_dco) begin
      if (!i_rst_n) begin
         phi_q <= PHI_W'(PHI_MIN);
      end else if (inc_rise && !dec_rise) begin
         if (phi_q <= PHI_W'(PHI_MAX - PHI_STEP)) begin
            phi_q <= phi_q + PHI_W'(PHI_STEP);
         end else begin
            phi_q <= PHI_W'(PHI_MAX);
         end
      end else if (dec_rise && !inc_rise) begin
         if (phi_q >= PHI_W'(PHI_MIN + PHI_STEP)) begin
            phi_q <= phi_q - PHI_W'(PHI_STEP);
         end else begin
            phi_q <= PHI_W'(PHI_MIN);
         end
      end
   end

   assign o_phi = phi_q;

endmodule

`default_nettype wire

// ==== hdl/tank_adc_capture.sv ====
// Tank ADC capture
`default_nettype none
`timescale 1ns/1ps

module tank_adc_capture (
   input  logic                                   i_clk_dco,
   input  logic                                   i_rst_n,
   input  logic signed [hc_ctrl_pkg::ADC_W-1:0]  i_ada_data,
   input  logic signed [hc_ctrl_pkg::ADC_W-1:0]  i_adb_data,
   input  logic                                   i_ada_or,
   input  logic                                   i_adb_or,
   tank_sample_if.src                             o_smp
);

   // valid only, samples never stall
   always_ff @(posedge i_clk_dco) begin
      if (!i_rst_n) begin
         o_smp.valid <= 1'b0;
      end else begin
         o_smp.valid <= 1'b1;
      end
   end

   // board signal chain is inverted, negate both words
   // channel a is vC, channel b is iC
   always_ff @(posedge i_clk_dco) begin
      o_smp.vc         <= -i_ada_data;
      o_smp.ic         <= -i_adb_data;
      // clip flag follows its sample
      o_smp.over_range <= i_ada_or | i_adb_or;
   end

endmodule

`default_nettype wire

// ==== hdl/tank_sample_if.sv ====
// Tank sample interface
`default_nettype none
`timescale 1ns/1ps

interface tank_sample_if;

   import hc_ctrl_pkg::*;

   // already in two's complement, sign fixed
   logic signed [ADC_W-1:0] vc;
   logic signed [ADC_W-1:0] ic;
   // either channel clipped
   logic                    over_range;
   // high every cycle after reset
   logic                    valid;

   modport src (output vc, output ic, output over_range, output valid);
   modport dst (input vc, input ic, input over_range, input valid);

endinterface

`default_nettype wire
